//--- compile.f
source/core_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/exec_stage.sv
source/int_core_top.sv
tb/int_core_assert.sv
tb/tb_int_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_int_core -f compile.f -o tb_int_core &&
    ./obj_dir/tb_int_core | tee /dev/stderr | grep -qx "test passed" &&
    echo "PASS" ||
    { echo "FAIL"; exit 1; }

//--- source/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // R-type view of an instruction word
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // I-type view of the same word
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    ////////////////////////////////////////////////////////////
    // Opcode and funct codes
    ////////////////////////////////////////////////////////////

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5,
        alu_lui = 3'd6
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////

    // Decode to execute
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic      use_imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     a;
        word_t     b;
        word_t     imm;
    } issue_t;

    // Write-back, also the register file write port
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

endpackage

//--- source/decode_stage.sv
module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // Instruction input
    input  logic      in_valid,
    input  instr_u    in_instr,

    // Register file read ports
    output reg_addr_t raddr_1,
    output logic      ren_1,
    input  word_t     rdata_1,
    output reg_addr_t raddr_2,
    output logic      ren_2,
    input  word_t     rdata_2,

    // To execute
    output issue_t    issue
);

    logic      legal;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      uses_rs;
    logic      uses_rt;
    reg_addr_t dest;
    word_t     imm_ext;

    ////////////////////////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        legal   = 1'b0;
        alu_op  = alu_add;
        use_imm = 1'b0;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        dest    = '0;
        imm_ext = '0;

        case (in_instr.r.opcode)
            op_special: begin
                // R-type, op from funct, result to rd
                legal   = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                dest    = in_instr.r.rd;
                case (in_instr.r.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    default: legal  = 1'b0;
                endcase
            end
            op_addiu: begin
                legal   = 1'b1;
                alu_op  = alu_add;
                use_imm = 1'b1;
                uses_rs = 1'b1;
                dest    = in_instr.i.rt;
                imm_ext = {{16{in_instr.i.imm[15]}}, in_instr.i.imm};
            end
            op_andi: begin
                legal   = 1'b1;
                alu_op  = alu_and;
                use_imm = 1'b1;
                uses_rs = 1'b1;
                dest    = in_instr.i.rt;
                imm_ext = {16'h0000, in_instr.i.imm};
            end
            op_ori: begin
                legal   = 1'b1;
                alu_op  = alu_or;
                use_imm = 1'b1;
                uses_rs = 1'b1;
                dest    = in_instr.i.rt;
                imm_ext = {16'h0000, in_instr.i.imm};
            end
            op_lui: begin
                // No source register, upper half only
                legal   = 1'b1;
                alu_op  = alu_lui;
                use_imm = 1'b1;
                dest    = in_instr.i.rt;
                imm_ext = {in_instr.i.imm, 16'h0000};
            end
            default: legal = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////////////////////////

    assign raddr_1 = in_instr.r.rs;
    assign raddr_2 = in_instr.r.rt;
    assign ren_1   = in_valid && legal && uses_rs;
    assign ren_2   = in_valid && legal && uses_rt;

    ////////////////////////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            issue <= '0;
        end else begin
            issue.valid   <= in_valid && legal;
            issue.alu_op  <= alu_op;
            issue.use_imm <= use_imm;
            // An unread operand carries r0 so it never matches a forward
            issue.rs      <= ren_1 ? raddr_1 : '0;
            issue.rt      <= ren_2 ? raddr_2 : '0;
            issue.dest    <= dest;
            issue.a       <= rdata_1;
            issue.b       <= rdata_2;
            issue.imm     <= imm_ext;
        end
    end

endmodule

//--- source/exec_stage.sv
module exec_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // From decode
    input  issue_t issue,

    // Write-back, also the forwarding source
    output wb_t    wb
);

    logic  fwd_a;
    logic  fwd_b;
    word_t op_a;
    word_t op_rt;
    word_t op_b;
    word_t result;

    ////////////////////////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////////////////////////

    // wb holds the result of the instruction one ahead
    // Older results come through the register file bypass
    assign fwd_a = wb.valid && wb.dest != '0 && wb.dest == issue.rs;
    assign fwd_b = wb.valid && wb.dest != '0 && wb.dest == issue.rt;

    assign op_a  = fwd_a ? wb.data : issue.a;
    assign op_rt = fwd_b ? wb.data : issue.b;

    // Immediate replaces rt for I-type
    assign op_b  = issue.use_imm ? issue.imm : op_rt;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_slt: begin
                // signed compare
                result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            alu_lui: result = op_b;
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb.valid <= issue.valid;
            wb.dest  <= issue.dest;
            wb.data  <= result;
        end
    end

endmodule

//--- source/int_core_top.sv
module int_core_top import core_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // Instruction stream, one per cycle
    input  logic   in_valid,
    input  instr_u in_instr,

    // Write-back report
    output wb_t    wb
);

    reg_addr_t raddr_1;
    reg_addr_t raddr_2;
    logic      ren_1;
    logic      ren_2;
    word_t     rdata_1;
    word_t     rdata_2;
    issue_t    issue;

    ////////////////////////////////////////////////////////////
    // Decode and operand read
    ////////////////////////////////////////////////////////////

    decode_stage decode_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .raddr_1  (raddr_1),
        .ren_1    (ren_1),
        .rdata_1  (rdata_1),
        .raddr_2  (raddr_2),
        .ren_2    (ren_2),
        .rdata_2  (rdata_2),
        .issue    (issue)
    );

    // Written from the execute output register
    reg_file reg_file_i (
        .clk     (clk),
        .rst     (rst),
        .raddr_1 (raddr_1),
        .ren_1   (ren_1),
        .rdata_1 (rdata_1),
        .raddr_2 (raddr_2),
        .ren_2   (ren_2),
        .rdata_2 (rdata_2),
        .wr      (wb)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    exec_stage exec_i (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .wb    (wb)
    );

endmodule

//--- source/reg_file.sv
module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // Read port 1
    input  reg_addr_t raddr_1,
    input  logic      ren_1,
    output word_t     rdata_1,

    // Read port 2
    input  reg_addr_t raddr_2,
    input  logic      ren_2,
    output word_t     rdata_2,

    // Write port
    input  wb_t       wr
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // r0 has no storage, it always reads as zero
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.dest != '0) begin
            regs[wr.dest] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Shared by both ports
    // A write landing this cycle is returned directly
    function automatic word_t read_port(input reg_addr_t addr, input logic en);
        word_t data;
        data = '0;
        if (en && addr != '0) begin
            if (wr.valid && wr.dest == addr) begin
                data = wr.data;
            end else begin
                data = regs[addr];
            end
        end
        return data;
    endfunction

    always_comb begin
        rdata_1 = read_port(raddr_1, ren_1);
    end

    always_comb begin
        rdata_2 = read_port(raddr_2, ren_2);
    end

endmodule

//--- tb/int_core_assert.sv
module int_core_assert import core_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   in_valid,
    input instr_u in_instr,
    input wb_t    wb
);

    int   fail_count = 0;
    logic legal_in;
    logic or_r0_in;

    function automatic logic is_legal(input instr_u w);
        case (w.r.opcode)
            op_special: return w.r.funct inside {fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt};
            op_addiu, op_andi, op_ori, op_lui: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    assign legal_in = in_valid && is_legal(in_instr);

    // or rX, r0, r0
    assign or_r0_in = legal_in && in_instr.r.opcode == op_special && in_instr.r.funct == fn_or
                      && in_instr.r.rs == 5'd0 && in_instr.r.rt == 5'd0;

    ////////////////////////////////////////////////////////////
    // Write-back port
    ////////////////////////////////////////////////////////////

    wb_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !wb.valid)
        else begin
            $error("wb.valid high in the first cycle after reset");
            fail_count++;
        end

    // Two edges of latency, with no reset in between
    wb_follows_legal: assert property (@(posedge clk) disable iff (rst)
        $past(legal_in, 2) && !$past(rst) && !$past(rst, 2) |-> wb.valid)
        else begin
            $error("legal instruction gave no write-back two edges later");
            fail_count++;
        end

    wb_only_from_legal: assert property (@(posedge clk) disable iff (rst)
        wb.valid |-> $past(legal_in, 2))
        else begin
            $error("write-back without a legal instruction two edges earlier");
            fail_count++;
        end

    r0_reads_zero: assert property (@(posedge clk) disable iff (rst)
        $past(or_r0_in, 2) && !$past(rst) && !$past(rst, 2) |-> wb.valid && wb.data == '0)
        else begin
            $error("or of r0 with r0 gave a non-zero result");
            fail_count++;
        end

endmodule

bind int_core_top int_core_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .wb       (wb)
);

//--- tb/tb_int_core.sv
module tb_int_core import core_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 5;
    localparam int n_random     = 200;
    localparam int drain_cycles = 3;

    logic   clk;
    logic   rst;
    logic   in_valid;
    instr_u in_instr;
    wb_t    wb;

    // Directed table
    instr_u dir_instr [$];
    logic   dir_valid [$];
    wb_t    dir_exp [$];

    // Expected write-back for each driven cycle
    wb_t    exp_q [$];
    word_t  ref_regs [0:31];

    logic [31:0] rand_state = 32'd17;
    logic        table_ready = 1'b0;
    int          n_checks = 0;
    int          n_errors = 0;

    int_core_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoding and reference model
    ////////////////////////////////////////////////////////////

    function automatic instr_u r_type(input logic [5:0] funct, input reg_addr_t rd,
                                      input reg_addr_t rs, input reg_addr_t rt);
        instr_u w;
        w.r.opcode = op_special;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic instr_u i_type(input logic [5:0] op, input reg_addr_t rt,
                                      input reg_addr_t rs, input logic [15:0] imm);
        instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic wb_t wb_exp(input reg_addr_t dest, input word_t data);
        wb_t e;
        e.valid = 1'b1;
        e.dest  = dest;
        e.data  = data;
        return e;
    endfunction

    function automatic logic [15:0] lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[31:16];
    endfunction

    function automatic wb_t model_wb(input instr_u w, input logic v);
        wb_t   e;
        word_t s;
        word_t t;
        word_t imm_z;
        s       = ref_regs[w.r.rs];
        t       = ref_regs[w.r.rt];
        imm_z   = {16'h0000, w.i.imm};
        e.valid = v;
        e.dest  = w.i.rt;
        e.data  = '0;
        case (w.r.opcode)
            op_special: begin
                e.dest = w.r.rd;
                case (w.r.funct)
                    fn_addu: e.data = s + t;
                    fn_subu: e.data = s - t;
                    fn_and:  e.data = s & t;
                    fn_or:   e.data = s | t;
                    fn_xor:  e.data = s ^ t;
                    fn_slt:  e.data = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
                    default: e.valid = 1'b0;
                endcase
            end
            op_addiu: e.data = s + {{16{w.i.imm[15]}}, w.i.imm};
            op_andi:  e.data = s & imm_z;
            op_ori:   e.data = s | imm_z;
            op_lui:   e.data = {w.i.imm, 16'h0000};
            default:  e.valid = 1'b0;
        endcase
        if (!e.valid) begin
            e = '0;
        end
        return e;
    endfunction

    function automatic instr_u random_instr();
        logic [15:0] sel;
        logic [15:0] imm;
        logic [5:0]  code;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        instr_u      w;
        sel  = lcg_next();
        imm  = lcg_next();
        code = imm[5:0];
        // Only r0 to r7, so dependencies come often
        rs   = {2'b00, sel[6:4]};
        rt   = {2'b00, sel[9:7]};
        rd   = {2'b00, sel[12:10]};
        case (sel[3:0])
            4'd0:  w = r_type(fn_addu, rd, rs, rt);
            4'd1:  w = r_type(fn_subu, rd, rs, rt);
            4'd2:  w = r_type(fn_and, rd, rs, rt);
            4'd3:  w = r_type(fn_or, rd, rs, rt);
            4'd4:  w = r_type(fn_xor, rd, rs, rt);
            4'd5:  w = r_type(fn_slt, rd, rs, rt);
            4'd6:  w = i_type(op_addiu, rt, rs, imm);
            4'd7:  w = i_type(op_andi, rt, rs, imm);
            4'd8:  w = i_type(op_ori, rt, rs, imm);
            4'd9:  w = i_type(op_lui, rt, rs, imm);
            4'd10: w = i_type(op_addiu, rt, rs, imm);
            4'd11: w = r_type(fn_subu, rd, rs, rt);
            4'd12, 4'd13: begin
                if (code inside {op_special, op_addiu, op_andi, op_ori, op_lui}) begin
                    code = 6'h23;
                end
                w = i_type(code, rt, rs, imm);
            end
            default: begin
                if (code inside {fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt}) begin
                    code = 6'h00;
                end
                w = r_type(code, rd, rs, rt);
            end
        endcase
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // Drive, compare and table
    ////////////////////////////////////////////////////////////

    task automatic step(input logic r, input logic v, input instr_u w, input wb_t e);
        @(posedge clk);
        rst      <= r;
        in_valid <= v;
        in_instr <= w;
        exp_q.push_back(e);
        if (r) begin
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
        end else if (e.valid && e.dest != 5'd0) begin
            ref_regs[e.dest] = e.data;
        end
    endtask

    task automatic apply_reset();
        repeat (reset_cycles) step(1'b1, 1'b0, '0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, 1'b0, '0, '0);
    endtask

    // dest and data only matter for a valid write-back
    task automatic check_wb(input wb_t actual, input wb_t expected, input string name);
        logic bad;
        n_checks++;
        bad = actual.valid !== expected.valid;
        if (expected.valid && (actual.dest !== expected.dest || actual.data !== expected.data))
            bad = 1'b1;
        if (bad) begin
            n_errors++;
            $display("** Error at %0t: %s = {valid %b, dest %0d, data %h}, expected {%b, %0d, %h}",
                     $time, name, actual.valid, actual.dest, actual.data,
                     expected.valid, expected.dest, expected.data);
        end
    endtask

    task automatic add_row(input instr_u w, input logic v, input wb_t e);
        dir_instr.push_back(w);
        dir_valid.push_back(v);
        dir_exp.push_back(e);
    endtask

    task automatic build_table();
        add_row(i_type(op_lui, 5'd1, 5'd0, 16'h1234), 1'b1, wb_exp(5'd1, 32'h12340000));
        add_row(i_type(op_ori, 5'd1, 5'd1, 16'h5678), 1'b1, wb_exp(5'd1, 32'h12345678));
        add_row(i_type(op_addiu, 5'd2, 5'd0, 16'hffff), 1'b1, wb_exp(5'd2, 32'hffffffff));
        add_row(i_type(op_andi, 5'd3, 5'd2, 16'h8001), 1'b1, wb_exp(5'd3, 32'h00008001));
        // r1 from storage and r2 through the bypass
        add_row(r_type(fn_addu, 5'd4, 5'd1, 5'd2), 1'b1, wb_exp(5'd4, 32'h12345677));
        add_row(r_type(fn_subu, 5'd5, 5'd4, 5'd3), 1'b1, wb_exp(5'd5, 32'h1233d676));
        add_row(r_type(fn_and, 5'd6, 5'd1, 5'd2), 1'b1, wb_exp(5'd6, 32'h12345678));
        add_row(r_type(fn_or, 5'd7, 5'd3, 5'd4), 1'b1, wb_exp(5'd7, 32'h1234d677));
        add_row(r_type(fn_xor, 5'd8, 5'd1, 5'd2), 1'b1, wb_exp(5'd8, 32'hedcba987));
        add_row(r_type(fn_slt, 5'd9, 5'd2, 5'd1), 1'b1, wb_exp(5'd9, 32'h00000001));
        add_row(r_type(fn_slt, 5'd10, 5'd1, 5'd2), 1'b1, wb_exp(5'd10, 32'h00000000));
        add_row(i_type(op_addiu, 5'd11, 5'd1, 16'h8000), 1'b1, wb_exp(5'd11, 32'h1233d678));
        add_row(i_type(op_ori, 5'd12, 5'd0, 16'h8000), 1'b1, wb_exp(5'd12, 32'h00008000));
        // Write to r0 is reported but r0 still reads zero
        add_row(r_type(fn_addu, 5'd0, 5'd1, 5'd1), 1'b1, wb_exp(5'd0, 32'h2468acf0));
        add_row(r_type(fn_or, 5'd13, 5'd0, 5'd0), 1'b1, wb_exp(5'd13, 32'h00000000));
        add_row(i_type(op_addiu, 5'd14, 5'd0, 16'h0005), 1'b1, wb_exp(5'd14, 32'h00000005));
        // Illegal opcode, illegal funct, legal word without in_valid
        add_row(i_type(6'h3f, 5'd1, 5'd1, 16'h1111), 1'b1, '0);
        add_row(r_type(6'h00, 5'd1, 5'd1, 5'd1), 1'b1, '0);
        add_row(i_type(op_addiu, 5'd1, 5'd0, 16'h0007), 1'b0, '0);
        add_row(r_type(fn_addu, 5'd15, 5'd1, 5'd0), 1'b1, wb_exp(5'd15, 32'h12345678));
        add_row(r_type(fn_slt, 5'd16, 5'd10, 5'd9), 1'b1, wb_exp(5'd16, 32'h00000001));
        add_row(i_type(op_lui, 5'd17, 5'd0, 16'h8000), 1'b1, wb_exp(5'd17, 32'h80000000));
        add_row(r_type(fn_slt, 5'd18, 5'd17, 5'd0), 1'b1, wb_exp(5'd18, 32'h00000001));
        add_row(r_type(fn_slt, 5'd19, 5'd0, 5'd17), 1'b1, wb_exp(5'd19, 32'h00000000));
        add_row(r_type(fn_subu, 5'd20, 5'd0, 5'd14), 1'b1, wb_exp(5'd20, 32'hfffffffb));
        add_row(i_type(op_andi, 5'd21, 5'd20, 16'hffff), 1'b1, wb_exp(5'd21, 32'h0000fffb));
    endtask

    function automatic int total_steps();
        return 2 * reset_cycles + dir_instr.size() + n_random + drain_cycles + 32;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checker, watchdog and main sequence
    ////////////////////////////////////////////////////////////

    // wb at a falling edge belongs to the entry pushed two rising edges before
    always @(negedge clk) begin
        if (exp_q.size() >= 3) begin
            check_wb(wb, exp_q.pop_front(), "wb");
        end
    end

    initial begin
        wait (table_ready);
        #((total_steps() + 20) * clk_period);
        $display("Watchdog expired, the run did not reach its end in time");
        $display("test failed");
        $finish;
    end

    initial begin
        instr_u      w;
        logic [15:0] r;
        int          n_assert;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        build_table();
        table_ready = 1'b1;
        apply_reset();

        for (int i = 0; i < dir_instr.size(); i++) begin
            step(1'b0, dir_valid[i], dir_instr[i], dir_exp[i]);
        end

        // Roughly one word in eight arrives without in_valid
        for (int i = 0; i < n_random; i++) begin
            w = random_instr();
            r = lcg_next();
            step(1'b0, r[2:0] != 3'd0, w, model_wb(w, r[2:0] != 3'd0));
        end

        // Reset hits while this word is still in execute, so its write-back is dropped
        step(1'b0, 1'b1, i_type(op_ori, 5'd1, 5'd0, 16'h00ff), '0);
        apply_reset();

        // Every register must read zero after the reset
        for (int k = 1; k < 32; k++) begin
            step(1'b0, 1'b1, r_type(fn_or, k[4:0], k[4:0], 5'd0), wb_exp(k[4:0], 32'h0));
        end
        idle(drain_cycles);
        repeat (2) @(negedge clk);

        n_assert = dut_i.assert_i.fail_count;
        $display("Checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, n_assert);
        if (n_errors == 0 && n_assert == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
